// File: verilog.f
+incdir+.
dispatchPkg.sv
rsEntryIf.sv
operandResolver.sv
dispatchRouter.sv
stationSlot.sv
dispatch.sv
tbDispatch.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tbDispatch
FILELIST  = verilog.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from a search of the simulation output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)

// File: tbDispatch.sv
`timescale 1ns/1ps
`include "dispatchDefines.svh"

module tbDispatch;
    import dispatchPkg::*;

    // 340 instructions take about 470 cycles with stalls, idles, reset and drains
    localparam int MAX_CYCLES = 600;

    logic clk, rst, idValid, idReady, aluReady, branchReady, lsbReady, rob1Hit, rob2Hit;
    logic reg1Ready, reg2Ready, rob1Ready, rob2Ready, robQuery1Valid, robQuery2Valid;
    logic aluValid, aluOpnd1Ready, aluOpnd2Ready, branchValid, branchOpnd1Ready;
    logic branchOpnd2Ready, lsbValid, lsbOpnd1Ready, lsbOpnd2Ready;
    logic [`OP_WIDTH-1:0] idOp, aluOp, branchOp, lsbOp;
    logic [`DATA_WIDTH-1:0] idImm, reg1Data, reg2Data, rob1Data, rob2Data, aluImm;
    logic [`DATA_WIDTH-1:0] aluOpnd1Data, aluOpnd2Data, branchImm, branchOpnd1Data;
    logic [`DATA_WIDTH-1:0] branchOpnd2Data, lsbImm, lsbOpnd1Data, lsbOpnd2Data;
    logic [`ADDR_WIDTH-1:0] idPc, aluPc, branchPc, lsbPc;
    logic [`TAG_WIDTH-1:0] idDestTag, reg1Tag, reg2Tag, robQuery1Tag, robQuery2Tag;
    logic [`TAG_WIDTH-1:0] aluDestTag, aluOpnd1Tag, aluOpnd2Tag, branchDestTag, branchOpnd1Tag;
    logic [`TAG_WIDTH-1:0] branchOpnd2Tag, lsbDestTag, lsbOpnd1Tag, lsbOpnd2Tag;

    // Station the decoder aimed at when it chose the opcode
    logic [1:0] idClass;
    logic stValid [3];
    logic stReady [3];
    logic stalled [3] = '{1'b0, 1'b0, 1'b0};
    rsEntryT stEntry [3];
    rsEntryT heldEntry [3];
    rsEntryT expQ [3][$];
    string stName [3] = '{"alu", "branch", "lsb"};
    string testName = "reset";
    int errorCount = 0;
    int acceptCount = 0;
    int testCount = 0;
    int cycleCount = 0;

    dispatch u_dut (.*);

    // Fixed ROB value for each tag
    function automatic logic [`DATA_WIDTH-1:0] robValue(logic [`TAG_WIDTH-1:0] tag);
        return {8{tag}} ^ 32'h3C5A_0F00;
    endfunction

    // ROB model answers only a live query
    assign rob1Ready = robQuery1Valid && rob1Hit;
    assign rob2Ready = robQuery2Valid && rob2Hit;
    assign rob1Data  = robValue(robQuery1Tag);
    assign rob2Data  = robValue(robQuery2Tag);

    // Stations indexed alu, branch, lsb
    assign stValid[0] = aluValid;
    assign stValid[1] = branchValid;
    assign stValid[2] = lsbValid;
    assign stReady[0] = aluReady;
    assign stReady[1] = branchReady;
    assign stReady[2] = lsbReady;
    assign stEntry[0] = {aluOp, aluImm, aluPc, aluDestTag, aluOpnd1Ready, aluOpnd1Data,
        aluOpnd1Tag, aluOpnd2Ready, aluOpnd2Data, aluOpnd2Tag};
    assign stEntry[1] = {branchOp, branchImm, branchPc, branchDestTag, branchOpnd1Ready,
        branchOpnd1Data, branchOpnd1Tag, branchOpnd2Ready, branchOpnd2Data, branchOpnd2Tag};
    assign stEntry[2] = {lsbOp, lsbImm, lsbPc, lsbDestTag, lsbOpnd1Ready, lsbOpnd1Data,
        lsbOpnd1Tag, lsbOpnd2Ready, lsbOpnd2Data, lsbOpnd2Tag};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycleCount);
            $display("Verification failed");
            $finish;
        end
    end

    // Ready operand compares on data and a pending one on tag
    function automatic bit operandMatches(operandT want, operandT got);
        if (want.ready) begin
            return got.ready && got.data == want.data;
        end
        return !got.ready && got.tag == want.tag;
    endfunction

    function automatic bit entryMatches(rsEntryT want, rsEntryT got);
        return want.op == got.op && want.imm == got.imm && want.pc == got.pc &&
            want.destTag == got.destTag && operandMatches(want.opnd1, got.opnd1) &&
            operandMatches(want.opnd2, got.opnd2);
    endfunction

    // ROB queried only for a live instruction with a pending register
    assert property (@(negedge clk) disable iff (rst) robQuery1Valid == (idValid && !reg1Ready)
        && (!robQuery1Valid || robQuery1Tag == reg1Tag))
    else begin
        $display("CHECK FAILED %s: ROB query 1 expected %b/%h actual %b/%h", testName,
            idValid && !reg1Ready, reg1Tag, robQuery1Valid, robQuery1Tag);
        errorCount++;
    end

    assert property (@(negedge clk) disable iff (rst) robQuery2Valid == (idValid && !reg2Ready)
        && (!robQuery2Valid || robQuery2Tag == reg2Tag))
    else begin
        $display("CHECK FAILED %s: ROB query 2 expected %b/%h actual %b/%h", testName,
            idValid && !reg2Ready, reg2Tag, robQuery2Valid, robQuery2Tag);
        errorCount++;
    end

    assert property (@(negedge clk) (rst || $past(rst)) |->
        !(aluValid || branchValid || lsbValid || robQuery1Valid || robQuery2Valid))
    else begin
        $display("A station valid or ROB query was high during or just after reset");
        errorCount++;
    end

    // Reference model sampled mid-cycle for the next rising edge
    always @(negedge clk) begin
        rsEntryT nextEntry;
        logic expReady;
        if (!rst) begin
            for (int s = 0; s < 3; s++) begin
                // One expected entry per occupied slot
                assert (expQ[s].size() == int'(stValid[s])) else begin
                    $display("CHECK FAILED %s: %s occupancy expected %0d actual %0d",
                        testName, stName[s], expQ[s].size(), stValid[s]);
                    errorCount++;
                end
                if (stValid[s] && expQ[s].size() != 0) begin
                    assert (entryMatches(expQ[s][0], stEntry[s])) else begin
                        $display("CHECK FAILED %s: %s entry expected %h actual %h",
                            testName, stName[s], expQ[s][0], stEntry[s]);
                        errorCount++;
                    end
                end
                // Stalled slot must hold still
                if (stalled[s]) begin
                    assert (stValid[s] && stEntry[s] == heldEntry[s]) else begin
                        $display("CHECK FAILED %s: %s held entry expected %h actual %h",
                            testName, stName[s], heldEntry[s], stEntry[s]);
                        errorCount++;
                    end
                end
                stalled[s] = stValid[s] && !stReady[s];
                heldEntry[s] = stEntry[s];
                if (stValid[s] && stReady[s] && expQ[s].size() != 0) begin
                    void'(expQ[s].pop_front());
                end
            end
            if (idValid) begin
                // Only a full target slot with its station stalled blocks the decoder
                expReady = !(stValid[idClass] && !stReady[idClass]);
                assert (idReady == expReady) else begin
                    $display("CHECK FAILED %s: idReady expected %b actual %b",
                        testName, expReady, idReady);
                    errorCount++;
                end
                if (idReady) begin
                    nextEntry.op = opcodeE'(idOp);
                    nextEntry.imm = idImm;
                    nextEntry.pc = idPc;
                    nextEntry.destTag = idDestTag;
                    nextEntry.opnd1 = '{reg1Ready || rob1Hit,
                        reg1Ready ? reg1Data : robValue(reg1Tag), reg1Tag};
                    nextEntry.opnd2 = '{reg2Ready || rob2Hit,
                        reg2Ready ? reg2Data : robValue(reg2Tag), reg2Tag};
                    expQ[idClass].push_back(nextEntry);
                end
            end
        end
    end

    task automatic runTest(input string name, input int count, input int regPct,
        input int robPct, input int idlePct, input int aluPct, input int branchPct,
        input int lsbPct);
        int sent;
        int startErrors;
        bit pending;
        sent = 0;
        pending = 1'b0;
        startErrors = errorCount;
        testName = name;
        while (sent < count) begin
            // New instruction only once the last one went through
            if (!pending) begin
                idValid = $urandom_range(99) >= idlePct;
                pending = idValid;
                idClass = 2'($urandom_range(2));
                case (idClass)
                    2'd0: idOp = `OP_WIDTH'($urandom_range(int'(AND), int'(NOP)));
                    2'd1: idOp = `OP_WIDTH'($urandom_range(int'(JALR), int'(BEQ)));
                    default: idOp = `OP_WIDTH'($urandom_range(int'(SW), int'(LB)));
                endcase
                idImm = $urandom();
                idPc = $urandom() & ~32'h3;
                idDestTag = `TAG_WIDTH'($urandom());
                reg1Ready = $urandom_range(99) < regPct;
                reg1Data = $urandom();
                reg1Tag = `TAG_WIDTH'($urandom());
                rob1Hit = $urandom_range(99) < robPct;
                reg2Ready = $urandom_range(99) < regPct;
                reg2Data = $urandom();
                reg2Tag = `TAG_WIDTH'($urandom());
                rob2Hit = $urandom_range(99) < robPct;
            end
            aluReady = $urandom_range(99) < aluPct;
            branchReady = $urandom_range(99) < branchPct;
            lsbReady = $urandom_range(99) < lsbPct;
            @(negedge clk);
            if (idValid && idReady) begin
                sent++;
                pending = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        // Let every slot empty before the next test
        {idValid, aluReady, branchReady, lsbReady} = 4'b0111;
        while (aluValid || branchValid || lsbValid) begin
            @(posedge clk);
            #1;
        end
        testCount++;
        acceptCount += count;
        $display("Test %s finished: %0d instructions, %0d errors", name, count,
            errorCount - startErrors);
    endtask

    initial begin
        void'($urandom(32'h1558_16a1));
        rst = 1'b1;
        idClass = 2'd0;
        {idValid, idOp, idImm, idPc, idDestTag} = '0;
        {reg1Ready, reg1Data, reg1Tag, reg2Ready, reg2Data, reg2Tag} = '0;
        {rob1Hit, rob2Hit, aluReady, branchReady, lsbReady} = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        runTest("regfile_operands", 60, 100, 0, 0, 100, 100, 100);
        runTest("rob_operands", 60, 0, 50, 10, 100, 100, 100);
        runTest("random_mix", 140, 50, 50, 10, 70, 70, 70);
        // Slow ALU station while branch and load/store keep flowing
        runTest("alu_backpressure", 80, 50, 50, 0, 40, 100, 100);
        $display("%0d tests, %0d instructions, %0d errors", testCount, acceptCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: dispatch.sv
`timescale 1ns/1ps
`include "dispatchDefines.svh"

module dispatch (
    input  logic                   clk,
    input  logic                   rst,
    // Decoder
    input  logic                   idValid,
    input  logic [`OP_WIDTH-1:0]   idOp,
    input  logic [`DATA_WIDTH-1:0] idImm,
    input  logic [`ADDR_WIDTH-1:0] idPc,
    input  logic [`TAG_WIDTH-1:0]  idDestTag,
    output logic                   idReady,
    // Register file
    input  logic                   reg1Ready,
    input  logic [`DATA_WIDTH-1:0] reg1Data,
    input  logic [`TAG_WIDTH-1:0]  reg1Tag,
    input  logic                   reg2Ready,
    input  logic [`DATA_WIDTH-1:0] reg2Data,
    input  logic [`TAG_WIDTH-1:0]  reg2Tag,
    // ROB query and answer
    output logic                   robQuery1Valid,
    output logic [`TAG_WIDTH-1:0]  robQuery1Tag,
    output logic                   robQuery2Valid,
    output logic [`TAG_WIDTH-1:0]  robQuery2Tag,
    input  logic                   rob1Ready,
    input  logic [`DATA_WIDTH-1:0] rob1Data,
    input  logic                   rob2Ready,
    input  logic [`DATA_WIDTH-1:0] rob2Data,
    // ALU station
    output logic                   aluValid,
    output logic [`OP_WIDTH-1:0]   aluOp,
    output logic [`DATA_WIDTH-1:0] aluImm,
    output logic [`ADDR_WIDTH-1:0] aluPc,
    output logic [`TAG_WIDTH-1:0]  aluDestTag,
    output logic                   aluOpnd1Ready,
    output logic [`DATA_WIDTH-1:0] aluOpnd1Data,
    output logic [`TAG_WIDTH-1:0]  aluOpnd1Tag,
    output logic                   aluOpnd2Ready,
    output logic [`DATA_WIDTH-1:0] aluOpnd2Data,
    output logic [`TAG_WIDTH-1:0]  aluOpnd2Tag,
    input  logic                   aluReady,
    // Branch station
    output logic                   branchValid,
    output logic [`OP_WIDTH-1:0]   branchOp,
    output logic [`DATA_WIDTH-1:0] branchImm,
    output logic [`ADDR_WIDTH-1:0] branchPc,
    output logic [`TAG_WIDTH-1:0]  branchDestTag,
    output logic                   branchOpnd1Ready,
    output logic [`DATA_WIDTH-1:0] branchOpnd1Data,
    output logic [`TAG_WIDTH-1:0]  branchOpnd1Tag,
    output logic                   branchOpnd2Ready,
    output logic [`DATA_WIDTH-1:0] branchOpnd2Data,
    output logic [`TAG_WIDTH-1:0]  branchOpnd2Tag,
    input  logic                   branchReady,
    // Load/store station
    output logic                   lsbValid,
    output logic [`OP_WIDTH-1:0]   lsbOp,
    output logic [`DATA_WIDTH-1:0] lsbImm,
    output logic [`ADDR_WIDTH-1:0] lsbPc,
    output logic [`TAG_WIDTH-1:0]  lsbDestTag,
    output logic                   lsbOpnd1Ready,
    output logic [`DATA_WIDTH-1:0] lsbOpnd1Data,
    output logic [`TAG_WIDTH-1:0]  lsbOpnd1Tag,
    output logic                   lsbOpnd2Ready,
    output logic [`DATA_WIDTH-1:0] lsbOpnd2Data,
    output logic [`TAG_WIDTH-1:0]  lsbOpnd2Tag,
    input  logic                   lsbReady
);
    import dispatchPkg::*;

    operandT opnd1;
    operandT opnd2;
    rsEntryT aluEntry;
    rsEntryT branchEntry;
    rsEntryT lsbEntry;

    rsEntryIf toAlu ();
    rsEntryIf toBranch ();
    rsEntryIf toLsb ();

    // Source operand 1
    operandResolver resolve1 (
        .regReady(reg1Ready), .regData(reg1Data), .regTag(reg1Tag),
        .robReady(rob1Ready), .robData(rob1Data), .active(idValid),
        .robQueryValid(robQuery1Valid), .robQueryTag(robQuery1Tag), .opnd(opnd1)
    );

    // Source operand 2
    operandResolver resolve2 (
        .regReady(reg2Ready), .regData(reg2Data), .regTag(reg2Tag),
        .robReady(rob2Ready), .robData(rob2Data), .active(idValid),
        .robQueryValid(robQuery2Valid), .robQueryTag(robQuery2Tag), .opnd(opnd2)
    );

    dispatchRouter router (
        .idValid(idValid), .idOp(opcodeE'(idOp)), .idImm(idImm), .idPc(idPc),
        .idDestTag(idDestTag), .idReady(idReady), .opnd1(opnd1), .opnd2(opnd2),
        .aluPort(toAlu.producer), .branchPort(toBranch.producer), .lsbPort(toLsb.producer)
    );

    // One registered slot per station
    stationSlot aluSlot (
        .clk(clk), .rst(rst), .upstream(toAlu.consumer),
        .outValid(aluValid), .outEntry(aluEntry), .outReady(aluReady)
    );

    stationSlot branchSlot (
        .clk(clk), .rst(rst), .upstream(toBranch.consumer),
        .outValid(branchValid), .outEntry(branchEntry), .outReady(branchReady)
    );

    stationSlot lsbSlot (
        .clk(clk), .rst(rst), .upstream(toLsb.consumer),
        .outValid(lsbValid), .outEntry(lsbEntry), .outReady(lsbReady)
    );

    // Flatten entries onto the station ports
    // Operand fields follow the struct order ready, data, tag
    assign {aluOp, aluImm, aluPc, aluDestTag} =
        {aluEntry.op, aluEntry.imm, aluEntry.pc, aluEntry.destTag};
    assign {aluOpnd1Ready, aluOpnd1Data, aluOpnd1Tag} = aluEntry.opnd1;
    assign {aluOpnd2Ready, aluOpnd2Data, aluOpnd2Tag} = aluEntry.opnd2;

    assign {branchOp, branchImm, branchPc, branchDestTag} =
        {branchEntry.op, branchEntry.imm, branchEntry.pc, branchEntry.destTag};
    assign {branchOpnd1Ready, branchOpnd1Data, branchOpnd1Tag} = branchEntry.opnd1;
    assign {branchOpnd2Ready, branchOpnd2Data, branchOpnd2Tag} = branchEntry.opnd2;

    assign {lsbOp, lsbImm, lsbPc, lsbDestTag} =
        {lsbEntry.op, lsbEntry.imm, lsbEntry.pc, lsbEntry.destTag};
    assign {lsbOpnd1Ready, lsbOpnd1Data, lsbOpnd1Tag} = lsbEntry.opnd1;
    assign {lsbOpnd2Ready, lsbOpnd2Data, lsbOpnd2Tag} = lsbEntry.opnd2;

endmodule

// File: stationSlot.sv
`timescale 1ns/1ps
`include "dispatchDefines.svh"

module stationSlot (
    input  logic                 clk,
    input  logic                 rst,
    // From the router
    rsEntryIf.consumer           upstream,
    // To the reservation station
    output logic                 outValid,
    output dispatchPkg::rsEntryT outEntry,
    input  logic                 outReady
);

    logic load;

    // Empty or emptying on this edge
    assign upstream.ready = !outValid || outReady;

    assign load = upstream.valid && upstream.ready;

    // Occupancy flag
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (load) begin
            // Covers refill on the same edge as a drain
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // Payload register
    // Held while the station stalls
    always_ff @(posedge clk) begin
        if (load) begin
            outEntry <= upstream.entry;
        end
    end

endmodule

// File: dispatchRouter.sv
`timescale 1ns/1ps
`include "dispatchDefines.svh"

module dispatchRouter (
    // Decoder side
    input  logic                   idValid,
    input  dispatchPkg::opcodeE    idOp,
    input  logic [`DATA_WIDTH-1:0] idImm,
    input  logic [`ADDR_WIDTH-1:0] idPc,
    input  logic [`TAG_WIDTH-1:0]  idDestTag,
    output logic                   idReady,
    // Resolved source operands
    input  dispatchPkg::operandT   opnd1,
    input  dispatchPkg::operandT   opnd2,
    // One port per station slot
    rsEntryIf.producer             aluPort,
    rsEntryIf.producer             branchPort,
    rsEntryIf.producer             lsbPort
);
    import dispatchPkg::*;

    stationE target;
    rsEntryT entry;

    // Station by opcode range
    // Anything unknown lands in the ALU
    always_comb begin
        if (idOp >= BEQ && idOp <= JALR) begin
            target = BRANCH_STATION;
        end else if (idOp >= LB && idOp <= SW) begin
            target = LSB_STATION;
        end else begin
            target = ALU_STATION;
        end
    end

    // Same entry offered to every slot
    always_comb begin
        entry.op      = idOp;
        entry.imm     = idImm;
        entry.pc      = idPc;
        entry.destTag = idDestTag;
        entry.opnd1   = opnd1;
        entry.opnd2   = opnd2;
    end

    assign aluPort.entry    = entry;
    assign branchPort.entry = entry;
    assign lsbPort.entry    = entry;

    // Only the chosen slot sees valid
    assign aluPort.valid    = idValid && (target == ALU_STATION);
    assign branchPort.valid = idValid && (target == BRANCH_STATION);
    assign lsbPort.valid    = idValid && (target == LSB_STATION);

    // Stall only on the targeted slot
    always_comb begin
        case (target)
            BRANCH_STATION: idReady = branchPort.ready;
            LSB_STATION:    idReady = lsbPort.ready;
            default:        idReady = aluPort.ready;
        endcase
    end

endmodule

// File: operandResolver.sv
`timescale 1ns/1ps
`include "dispatchDefines.svh"

module operandResolver (
    // Register file lookup
    input  logic                   regReady,
    input  logic [`DATA_WIDTH-1:0] regData,
    input  logic [`TAG_WIDTH-1:0]  regTag,
    // ROB answer in the same cycle as the query
    input  logic                   robReady,
    input  logic [`DATA_WIDTH-1:0] robData,
    // Decoder has an instruction this cycle
    input  logic                   active,
    // ROB query
    output logic                   robQueryValid,
    output logic [`TAG_WIDTH-1:0]  robQueryTag,
    // Resolved operand to the router
    output dispatchPkg::operandT   opnd
);

    // Only ask the ROB when the register file has no value
    assign robQueryValid = active && !regReady;
    assign robQueryTag   = regTag;

    always_comb begin
        // Tag passes through and is ignored once ready is set
        opnd.tag = regTag;
        if (regReady) begin
            // Committed value in the register file
            opnd.ready = 1'b1;
            opnd.data  = regData;
        end else if (robReady) begin
            // Finished but not yet committed
            opnd.ready = 1'b1;
            opnd.data  = robData;
        end else begin
            // Still in flight so the station waits on the tag
            opnd.ready = 1'b0;
            opnd.data  = '0;
        end
    end

endmodule

// File: rsEntryIf.sv
`timescale 1ns/1ps
`include "dispatchDefines.svh"

// One station entry travelling from router to output slot
interface rsEntryIf;

    // Router has an entry for this station
    logic valid;

    // Slot can take it this cycle
    logic ready;

    // Payload meaningful only with valid high
    dispatchPkg::rsEntryT entry;

    // Router side
    modport producer (
        output valid,
        output entry,
        input  ready
    );

    // Slot side
    modport consumer (
        input  valid,
        input  entry,
        output ready
    );

endinterface

// File: dispatchPkg.sv
`include "dispatchDefines.svh"

package dispatchPkg;

    // Grouped so that classification is a range compare
    typedef enum logic [`OP_WIDTH-1:0] {
        NOP,
        // ALU group
        LUI, AUIPC,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        // Branch and jump group
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        // Load/store group
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } opcodeE;

    // Target reservation station
    typedef enum logic [1:0] {
        ALU_STATION,
        BRANCH_STATION,
        LSB_STATION
    } stationE;

    // Source operand as a value or a pending ROB tag
    typedef struct packed {
        logic                   ready;
        logic [`DATA_WIDTH-1:0] data;
        // Producer entry while ready is low
        logic [`TAG_WIDTH-1:0]  tag;
    } operandT;

    // One reservation station entry
    typedef struct packed {
        opcodeE                 op;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`ADDR_WIDTH-1:0] pc;
        logic [`TAG_WIDTH-1:0]  destTag;
        operandT                opnd1;
        operandT                opnd2;
    } rsEntryT;

endpackage

// File: dispatchDefines.svh
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// Operand and immediate width
`define DATA_WIDTH 32

// Program counter width
`define ADDR_WIDTH 32

// ROB tag width for 16 entries
`define TAG_WIDTH 4

// Opcode field width
// Room for the full RV32I set plus NOP
`define OP_WIDTH 6

`endif
